//--- Makefile
# Verilator build and run of the Ising core testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module tb_ising_core \
		-f flist.f -Mdir obj_dir -o tb_ising_core
	./obj_dir/tb_ising_core

clean:
	rm -rf obj_dir

//--- flist.f
verilog/ising_pkg.sv
verilog/spin_sweep_ctrl.sv
verilog/spin_lane.sv
verilog/sweep_collector.sv
verilog/ising_core.sv
sim/tb_clock_gen.sv
sim/tb_ising_core.sv

//--- sim/ising_stimulus.txt
# L/B <row> <word hex, element 7 first>: rows 0-7 couplings, row 8 bias; B loads while busy
# R <init spins hex> <max sweeps> <stop on stable>; E <sweep index> <spins hex> <energy>
# Reset state, all fields zero
R 5a 1 0
E 1 ff 0
# Couplings and bias
L 0 00000010
L 1 00000000
L 2 00000000
L 3 00000f00
L 4 00000002
L 5 00020000
L 6 000000e0
L 7 0f300000
L 8 0101d3d3
# Single sweep
R ff 1 0
E 1 b5 -6
# Four sweeps without early stop
R 5a 4 0
E 1 25 12
E 2 d5 0
E 3 75 -12
E 4 f5 -18
# Early stop, sweep 5 repeats its input
R 5a 8 1
E 1 25 12
E 2 d5 0
E 3 75 -12
E 4 f5 -18
E 5 f5 -22
# Loads during a run are dropped
R 5a 4 0
B 4 00000077
B 8 77777777
E 1 25 12
E 2 d5 0
E 3 75 -12
E 4 f5 -18
# Stable start keeps going with early stop off
R f5 2 0
E 1 f5 -22
E 2 f5 -22

//--- sim/tb_clock_gen.sv
// Testbench clock source
module tb_clock_gen #(
    parameter int PERIOD = 20
)(
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

endmodule

//--- sim/tb_ising_core.sv
// Ising core testbench
module tb_ising_core import ising_pkg::*; ();

    localparam int CNT_W          = 8;
    localparam int RESULT_TIMEOUT = 4 * (NUM_SPIN + 2);
    localparam int BUSY_TIMEOUT   = 256 * (NUM_SPIN + 2);
    localparam int QUIET_CYCLES   = 2 * (NUM_SPIN + 2);

    logic          clk;
    logic          rst_n;
    load_req_t     load;
    logic          start;
    run_cfg_t      run_cfg;
    logic          busy;
    logic          result_valid;
    sweep_result_t result;

    sweep_result_t results_q[$];
    logic [31:0]   lfsr;
    logic          run_open;

    tb_clock_gen #(
        .PERIOD (20 )
    ) u_clk (
        .clk_o  (clk)
    );

    ising_core #(
        .CNT_W          (CNT_W       )
    ) UUT (
        .clk_i          (clk         ),
        .rst_n_i        (rst_n       ),
        .load_i         (load        ),
        .start_i        (start       ),
        .run_cfg_i      (run_cfg     ),
        .busy_o         (busy        ),
        .result_valid_o (result_valid),
        .result_o       (result      )
    );

    // Catch every one-cycle result pulse
    always @(negedge clk) begin
        if (result_valid) begin
            results_q.push_back(result);
        end
    end

    ////////////////////////////////////////
    // Failure reporting and checks
    ////////////////////////////////////////
    task automatic stop_with_failure();
        $display("Simulation FAILED");
        $fatal(1, "Testbench stopped at the first failure");
    endtask

    task automatic value_error(input string msg);
        $display("** Error at time %0t: %s", $time, msg);
        stop_with_failure();
    endtask

    task automatic abort_run(input string msg);
        $display("Testbench failure at time %0t: %s", $time, msg);
        stop_with_failure();
    endtask

    task automatic check_spins(input spin_vec_t got, input spin_vec_t exp);
        if (got !== exp) begin
            value_error($sformatf("spins are %h, expected %h", got, exp));
        end
    endtask

    task automatic check_energy(input logic signed [ENERGY_W-1:0] got,
                                input logic signed [ENERGY_W-1:0] exp);
        if (got !== exp) begin
            value_error($sformatf("energy is %0d, expected %0d", got, exp));
        end
    endtask

    task automatic check_index(input logic [SWEEP_W-1:0] got, input logic [SWEEP_W-1:0] exp);
        if (got !== exp) begin
            value_error($sformatf("sweep index is %0d, expected %0d", got, exp));
        end
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h8020_0003;
        end
        return next;
    endfunction

    // 0 to 3 idle cycles from two LFSR bits
    task automatic idle_gap();
        int gap;
        gap = 0;
        for (int b = 0; b < 2; b++) begin
            gap  = (gap << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
        repeat (gap) @(posedge clk);
    endtask

    task automatic issue_load(input int addr, input load_word_u word, input logic while_busy);
        @(posedge clk);
        load.strobe <= 1'b1;
        load.addr   <= LOAD_ADDR_W'(addr);
        load.data   <= word;
        @(negedge clk);
        if (while_busy && !busy) begin
            abort_run("a load meant for a busy core was issued while it was idle");
        end
        @(posedge clk);
        load.strobe <= 1'b0;
    endtask

    task automatic start_run(input spin_vec_t init, input int max, input logic stop);
        @(posedge clk);
        start                  <= 1'b1;
        run_cfg.init_spins     <= init;
        run_cfg.max_sweeps     <= SWEEP_W'(max);
        run_cfg.stop_on_stable <= stop;
        @(posedge clk);
        start    <= 1'b0;
        run_open = 1'b1;
    endtask

    task automatic expect_result(input int index, input spin_vec_t spins, input int energy);
        sweep_result_t got;
        int            waited;
        waited = 0;
        while (results_q.size() == 0) begin
            if (waited == RESULT_TIMEOUT) begin
                abort_run($sformatf("no result arrived for sweep %0d", index));
            end
            @(posedge clk);
            waited++;
        end
        got = results_q.pop_front();
        check_index(got.index, SWEEP_W'(index));
        check_spins(got.spins, spins);
        check_energy(got.energy, ENERGY_W'(energy));
    endtask

    // Wait for the run to end and stay quiet
    task automatic finish_run();
        int waited;
        waited = 0;
        @(negedge clk);
        while (busy) begin
            if (waited == BUSY_TIMEOUT) begin
                abort_run("busy_o did not fall at the end of the run");
            end
            @(negedge clk);
            waited++;
        end
        repeat (QUIET_CYCLES) @(posedge clk);
        if (results_q.size() != 0) begin
            abort_run($sformatf("%0d result(s) came beyond the expected ones", results_q.size()));
        end
        run_open = 1'b0;
    endtask

    initial begin
        int          fd;
        int          count;
        int          addr;
        int          num;
        int          value;
        string       line;
        byte         kind;
        logic [31:0] word;
        spin_vec_t   spins;
        rst_n    = 1'b0;
        load     = '0;
        start    = 1'b0;
        run_cfg  = '0;
        lfsr     = 32'h2ed2;
        run_open = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (busy !== 1'b0 || result_valid !== 1'b0) begin
            value_error("busy_o or result_valid_o is not low after reset");
        end
        fd = $fopen("sim/ising_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open sim/ising_stimulus.txt");
        end
        while ($fgets(line, fd) != 0) begin
            kind  = 8'h00;
            count = $sscanf(line, "%c", kind);
            case (kind)
                "L", "B": begin
                    count = $sscanf(line, "%c %d %h", kind, addr, word);
                    if (count != 3) begin
                        abort_run($sformatf("malformed load line: %s", line));
                    end
                    if (kind == "L" && run_open) begin
                        finish_run();
                    end
                    idle_gap();
                    issue_load(addr, word, kind == "B");
                end
                "R": begin
                    count = $sscanf(line, "R %h %d %d", spins, num, value);
                    if (count != 3) begin
                        abort_run($sformatf("malformed run line: %s", line));
                    end
                    if (run_open) begin
                        finish_run();
                    end
                    idle_gap();
                    start_run(spins, num, value[0]);
                end
                "E": begin
                    count = $sscanf(line, "E %d %h %d", num, spins, value);
                    if (count != 3) begin
                        abort_run($sformatf("malformed expected line: %s", line));
                    end
                    expect_result(num, spins, value);
                end
                "#", "\n": begin
                end
                default: begin
                    abort_run($sformatf("unrecognized stimulus line: %s", line));
                end
            endcase
        end
        $fclose(fd);
        if (run_open) begin
            finish_run();
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- verilog/ising_core.sv
// Ising machine core top
module ising_core import ising_pkg::*; #(
    parameter int CNT_W = 8
)(
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  load_req_t     load_i,
    input  logic          start_i,
    input  run_cfg_t      run_cfg_i,
    output logic          busy_o,
    output logic          result_valid_o,
    output sweep_result_t result_o
);

    column_t                  column;
    spin_vec_t                row_we;
    logic                     h_we;
    load_word_u               load_word;
    lane_out_t [NUM_SPIN-1:0] lanes;
    sweep_fb_t                fb;
    logic                     fb_valid;

    spin_sweep_ctrl #(
        .CNT_W       (CNT_W    )
    ) u_ctrl (
        .clk_i       (clk_i    ),
        .rst_n_i     (rst_n_i  ),
        .load_i      (load_i   ),
        .start_i     (start_i  ),
        .run_cfg_i   (run_cfg_i),
        .fb_i        (fb       ),
        .fb_valid_i  (fb_valid ),
        .column_o    (column   ),
        .row_we_o    (row_we   ),
        .h_we_o      (h_we     ),
        .load_word_o (load_word),
        .busy_o      (busy_o   )
    );

    ////////////////////////////////////////
    // Lane array
    ////////////////////////////////////////
    for (genvar i = 0; i < NUM_SPIN; i++) begin : g_lane
        spin_lane #(
            .LANE_IDX    (i        )
        ) u_lane (
            .clk_i       (clk_i    ),
            .rst_n_i     (rst_n_i  ),
            .column_i    (column   ),
            .row_we_i    (row_we[i]),
            .h_we_i      (h_we     ),
            .load_word_i (load_word),
            .lane_o      (lanes[i] )
        );
    end

    sweep_collector #(
        .CNT_W          (CNT_W         )
    ) u_collector (
        .clk_i          (clk_i         ),
        .rst_n_i        (rst_n_i       ),
        .column_i       (column        ),
        .lanes_i        (lanes         ),
        .fb_o           (fb            ),
        .fb_valid_o     (fb_valid      ),
        .result_valid_o (result_valid_o),
        .result_o       (result_o      )
    );

endmodule

//--- verilog/ising_pkg.sv
// Ising core shared types
package ising_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////
    localparam int NUM_SPIN    = 8;
    localparam int BIT_J       = 4;
    localparam int BIT_H       = 4;
    localparam int FIELD_W     = 8;
    localparam int ENERGY_W    = 12;
    localparam int SWEEP_W     = 8;
    localparam int IDX_W       = $clog2(NUM_SPIN);
    // Rows 0..NUM_SPIN-1 are couplings and row NUM_SPIN is the bias vector
    localparam int LOAD_ADDR_W = $clog2(NUM_SPIN + 1);

    ////////////////////////////////////////
    // Spin and weight words
    ////////////////////////////////////////
    typedef logic [NUM_SPIN-1:0] spin_vec_t;

    typedef logic signed [BIT_J-1:0] j_elem_t;
    typedef logic signed [BIT_H-1:0] h_elem_t;

    typedef j_elem_t [NUM_SPIN-1:0] j_row_t;
    typedef h_elem_t [NUM_SPIN-1:0] h_vec_t;

    // One word whose meaning the load address picks
    typedef union packed {
        j_row_t j_row;
        h_vec_t h_vec;
    } load_word_u;

    typedef struct packed {
        logic                   strobe;
        logic [LOAD_ADDR_W-1:0] addr;
        load_word_u             data;
    } load_req_t;

    typedef struct packed {
        spin_vec_t          init_spins;
        logic [SWEEP_W-1:0] max_sweeps;
        logic               stop_on_stable;
    } run_cfg_t;

    ////////////////////////////////////////
    // Internal traffic and results
    ////////////////////////////////////////
    typedef struct packed {
        logic             first;
        logic             last;
        logic [IDX_W-1:0] idx;
        logic             spin;
    } column_t;

    typedef struct packed {
        logic                      valid;
        logic                      spin;
        logic signed [FIELD_W-1:0] prod;
    } lane_out_t;

    typedef struct packed {
        spin_vec_t                  spins;
        logic signed [ENERGY_W-1:0] energy;
        logic [SWEEP_W-1:0]         index;
    } sweep_result_t;

    typedef struct packed {
        spin_vec_t spins;
        logic      stable;
    } sweep_fb_t;

endpackage

//--- verilog/spin_lane.sv
// Spin lane
module spin_lane import ising_pkg::*; #(
    parameter int LANE_IDX = 0
)(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  column_t    column_i,
    input  logic       row_we_i,
    input  logic       h_we_i,
    input  load_word_u load_word_i,
    output lane_out_t  lane_o
);

    j_row_t                    row_q;
    h_elem_t                   h_q;
    logic signed [FIELD_W-1:0] j_ext;
    logic signed [FIELD_W-1:0] h_ext;
    logic signed [FIELD_W-1:0] term;
    logic signed [FIELD_W-1:0] field;
    logic signed [FIELD_W-1:0] acc_q;
    logic                      old_spin_q;
    logic                      old_spin;
    logic                      valid_q;
    logic                      spin_q;
    logic signed [FIELD_W-1:0] prod_q;

    ////////////////////////////////////////
    // Weight storage
    ////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            row_q <= '0;
            h_q   <= '0;
        end else begin
            if (row_we_i) begin
                row_q <= load_word_i.j_row;
            end
            if (h_we_i) begin
                h_q <= load_word_i.h_vec[LANE_IDX];
            end
        end
    end

    ////////////////////////////////////////
    // Field accumulation
    ////////////////////////////////////////
    assign j_ext = $signed(row_q[column_i.idx]);
    assign h_ext = h_q;
    assign term  = column_i.spin ? j_ext : -j_ext;
    // Bias seeds the sum on the first beat
    assign field = (column_i.first ? h_ext : acc_q) + term;

    // Own spin may arrive on the last beat itself
    assign old_spin = (column_i.idx == IDX_W'(LANE_IDX)) ? column_i.spin : old_spin_q;

    always_ff @(posedge clk_i) begin
        acc_q <= field;
        if (column_i.idx == IDX_W'(LANE_IDX)) begin
            old_spin_q <= column_i.spin;
        end
        if (column_i.last) begin
            spin_q <= ~field[FIELD_W-1];
            prod_q <= old_spin ? field : -field;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= column_i.last;
        end
    end

    assign lane_o.valid = valid_q;
    assign lane_o.spin  = spin_q;
    assign lane_o.prod  = prod_q;

endmodule

//--- verilog/spin_sweep_ctrl.sv
// Sweep controller
module spin_sweep_ctrl import ising_pkg::*; #(
    parameter int CNT_W = 8
)(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  load_req_t  load_i,
    input  logic       start_i,
    input  run_cfg_t   run_cfg_i,
    input  sweep_fb_t  fb_i,
    input  logic       fb_valid_i,
    output column_t    column_o,
    output spin_vec_t  row_we_o,
    output logic       h_we_o,
    output load_word_u load_word_o,
    output logic       busy_o
);

    logic             busy_q;
    logic             beat_en_q;
    logic [IDX_W-1:0] beat_q;
    spin_vec_t        spins_q;
    logic [CNT_W-1:0] max_q;
    logic             stop_q;
    logic [CNT_W-1:0] sweep_q;
    logic             run_done;
    logic             last_beat;

    ////////////////////////////////////////
    // Load decode while idle
    ////////////////////////////////////////
    always_comb begin
        row_we_o = '0;
        h_we_o   = 1'b0;
        if (load_i.strobe && !busy_q) begin
            if (load_i.addr == LOAD_ADDR_W'(NUM_SPIN)) begin
                h_we_o = 1'b1;
            end else if (load_i.addr < LOAD_ADDR_W'(NUM_SPIN)) begin
                row_we_o[load_i.addr[IDX_W-1:0]] = 1'b1;
            end
        end
    end

    assign load_word_o = load_i.data;

    ////////////////////////////////////////
    // Column broadcast
    ////////////////////////////////////////
    assign last_beat       = (beat_q == IDX_W'(NUM_SPIN - 1));
    assign column_o.first  = beat_en_q && (beat_q == '0);
    assign column_o.last   = beat_en_q && last_beat;
    assign column_o.idx    = beat_q;
    assign column_o.spin   = spins_q[beat_q];

    // Stop on sweep limit or on a settled state
    assign run_done = ((sweep_q + CNT_W'(1)) >= max_q) || (stop_q && fb_i.stable);
    assign busy_o   = busy_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q    <= 1'b0;
            beat_en_q <= 1'b0;
            beat_q    <= '0;
            spins_q   <= '0;
            max_q     <= '0;
            stop_q    <= 1'b0;
            sweep_q   <= '0;
        end else if (!busy_q) begin
            if (start_i) begin
                busy_q    <= 1'b1;
                beat_en_q <= 1'b1;
                beat_q    <= '0;
                spins_q   <= run_cfg_i.init_spins;
                // Zero sweeps runs once
                max_q     <= (run_cfg_i.max_sweeps == '0) ? CNT_W'(1)
                                                          : CNT_W'(run_cfg_i.max_sweeps);
                stop_q    <= run_cfg_i.stop_on_stable;
                sweep_q   <= '0;
            end
        end else begin
            if (beat_en_q) begin
                beat_q <= last_beat ? '0 : beat_q + 1'b1;
                if (last_beat) begin
                    beat_en_q <= 1'b0;
                end
            end
            if (fb_valid_i) begin
                spins_q <= fb_i.spins;
                sweep_q <= sweep_q + 1'b1;
                if (run_done) begin
                    busy_q <= 1'b0;
                end else begin
                    beat_en_q <= 1'b1;
                    beat_q    <= '0;
                end
            end
        end
    end

endmodule

//--- verilog/sweep_collector.sv
// Sweep result collector
module sweep_collector import ising_pkg::*; #(
    parameter int CNT_W = 8
)(
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  column_t                  column_i,
    input  lane_out_t [NUM_SPIN-1:0] lanes_i,
    output sweep_fb_t                fb_o,
    output logic                     fb_valid_o,
    output logic                     result_valid_o,
    output sweep_result_t            result_o
);

    logic                       all_valid;
    spin_vec_t                  new_spins;
    logic signed [ENERGY_W-1:0] prod_sum;
    spin_vec_t                  prev_q;
    logic                       in_sweep_q;
    logic [CNT_W-1:0]           cnt_q;
    logic                       valid_q;
    logic                       chain_q;
    logic                       stable_q;
    sweep_result_t              result_q;

    always_comb begin
        all_valid = 1'b1;
        new_spins = '0;
        prod_sum  = '0;
        for (int i = 0; i < NUM_SPIN; i++) begin
            all_valid    = all_valid & lanes_i[i].valid;
            new_spins[i] = lanes_i[i].spin;
            prod_sum     = prod_sum + $signed(lanes_i[i].prod);
        end
    end

    ////////////////////////////////////////
    // Spins going into the sweep
    ////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (column_i.first || in_sweep_q) begin
            prev_q[column_i.idx] <= column_i.spin;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            in_sweep_q <= 1'b0;
            valid_q    <= 1'b0;
            chain_q    <= 1'b0;
            cnt_q      <= '0;
        end else begin
            in_sweep_q <= (in_sweep_q | column_i.first) & ~column_i.last;
            valid_q    <= all_valid;
            chain_q    <= valid_q;
            // A first beat not right after a result starts a new run
            if (column_i.first && !chain_q) begin
                cnt_q <= '0;
            end else if (all_valid) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (all_valid) begin
            result_q.spins  <= new_spins;
            result_q.energy <= -prod_sum;
            result_q.index  <= SWEEP_W'(cnt_q + CNT_W'(1));
            stable_q        <= (new_spins == prev_q);
        end
    end

    assign result_o       = result_q;
    assign result_valid_o = valid_q;
    assign fb_valid_o     = valid_q;
    assign fb_o.spins     = result_q.spins;
    assign fb_o.stable    = stable_q;

endmodule
